/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_tiny_cpu
FILELIST  ?= tiny_cpu.f
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* sim/cpu_checker.sv */
`timescale 1ns/100ps

module cpu_checker (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             instr_valid,
	input  logic [tiny_cpu_pkg::INSTR_W-1:0] instr,
	input  tiny_cpu_pkg::wb_t                wb,
	input  logic [15:0]                      debug_out,
	output int                               error_count,
	output int                               check_count
);

	localparam int DBG_A = 4;
	localparam int DBG_B = 5;

	// Issue-order model and the state the register file has committed
	logic [15:0]       arch_regs [0:15];
	logic [15:0]       done_regs [0:15];
	logic [15:0]       model_count;
	tiny_cpu_pkg::wb_t exp_stage1;
	tiny_cpu_pkg::wb_t exp_stage2;
	int                cyc_errs;
	int                cyc_checks;
	int                errs_total = 0;
	int                checks_total = 0;

	assign error_count = errs_total;
	assign check_count = checks_total;

	// Expected writeback of one instruction
	function automatic tiny_cpu_pkg::wb_t predict(input logic [15:0] word,
		input logic [15:0] count);
		tiny_cpu_pkg::wb_t w;
		logic [3:0]        op;
		logic [3:0]        rd;
		logic [15:0]       a;
		logic [15:0]       b;
		logic [15:0]       res;
		op = word[15:12];
		rd = word[11:8];
		a = arch_regs[word[7:4]];
		b = arch_regs[word[3:0]];
		w = '0;
		case (op)
			tiny_cpu_pkg::OP_ADD:  res = a + b;
			tiny_cpu_pkg::OP_SUB:  res = a - b;
			tiny_cpu_pkg::OP_AND:  res = a & b;
			tiny_cpu_pkg::OP_OR:   res = a | b;
			tiny_cpu_pkg::OP_XOR:  res = a ^ b;
			tiny_cpu_pkg::OP_SHL:  res = a << b[3:0];
			tiny_cpu_pkg::OP_SHR:  res = a >> b[3:0];
			tiny_cpu_pkg::OP_ADDI: res = a + {12'h000, word[3:0]};
			tiny_cpu_pkg::OP_LUI:  res = {word[7:0], 8'h00};
			tiny_cpu_pkg::OP_CALL: res = count + 16'd1;
			default:               res = '0;
		endcase
		if (op == tiny_cpu_pkg::OP_CALL) begin
			w.valid = 1'b1;
			w.link  = 1'b1;
			w.addr  = tiny_cpu_pkg::LINK_REG;
			w.value = res;
		end else if (op >= tiny_cpu_pkg::OP_ADD && op <= tiny_cpu_pkg::OP_LUI &&
		             rd != tiny_cpu_pkg::ZERO_REG && rd != tiny_cpu_pkg::LINK_REG) begin
			w.valid = 1'b1;
			w.addr  = rd;
			w.value = res;
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		cyc_checks++;
		if (exp !== act) begin
			$display("FAIL %0t ns %s expected %h got %h", $time, name, exp, act);
			cyc_errs++;
		end
	endtask

	task automatic compare_wb(input tiny_cpu_pkg::wb_t exp);
		cyc_checks++;
		if (exp.valid && wb.valid !== 1'b1) begin
			$display("%0t ns: writeback of register %0d with value %h never came",
				$time, exp.addr, exp.value);
			cyc_errs++;
		end else if (!exp.valid && wb.valid !== 1'b0) begin
			$display("%0t ns: writeback to register %0d came when none was expected",
				$time, wb.addr);
			cyc_errs++;
		end else if (exp.valid) begin
			check_value("wb.addr", {12'h000, exp.addr}, {12'h000, wb.addr});
			check_value("wb.value", exp.value, wb.value);
			check_value("wb.link", {15'h0000, exp.link}, {15'h0000, wb.link});
		end
	endtask

	always @(posedge clk) begin
		cyc_errs = 0;
		cyc_checks = 0;
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				arch_regs[i] = '0;
				done_regs[i] = '0;
			end
			model_count = '0;
			exp_stage1 = '0;
			exp_stage2 = '0;
		end else begin
			check_value("debug_out", {done_regs[DBG_A][7:0], done_regs[DBG_B][7:0]},
				debug_out);
			compare_wb(exp_stage2);
			if (exp_stage2.valid)
				done_regs[exp_stage2.addr] = exp_stage2.value;
			exp_stage2 = exp_stage1;
			exp_stage1 = '0;
			if (instr_valid) begin
				exp_stage1 = predict(instr, model_count);
				if (exp_stage1.valid)
					arch_regs[exp_stage1.addr] = exp_stage1.value;
				model_count = model_count + 16'd1;
			end
		end
		errs_total <= errs_total + cyc_errs;
		checks_total <= checks_total + cyc_checks;
	end

endmodule

/* sim/cpu_properties.sv */
`timescale 1ns/100ps

module cpu_properties (
	input logic                            clk,
	input logic                            rst_n,
	input tiny_cpu_pkg::wb_t               wb,
	input logic                            gen_write,
	input logic                            link_write,
	input tiny_cpu_pkg::decoded_t          decoded,
	input logic [tiny_cpu_pkg::DATA_W-1:0] read_value1,
	input logic [tiny_cpu_pkg::DATA_W-1:0] read_value2
);

	// A reported writeback always names a real register
	wb_addr_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> wb.addr != tiny_cpu_pkg::ZERO_REG)
		else $error("writeback reported for the zero register");

	// Each port has its own target, so the two never fire together
	link_port_target: assert property (@(posedge clk) disable iff (!rst_n)
		link_write |-> wb.addr == tiny_cpu_pkg::LINK_REG)
		else $error("link port write not aimed at the link register");

	general_port_target: assert property (@(posedge clk) disable iff (!rst_n)
		gen_write |-> wb.addr != tiny_cpu_pkg::LINK_REG)
		else $error("general port write aimed at the link register");

	wb_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !wb.valid)
		else $error("writeback valid right after reset");

	// Zero register reads as zero on both ports
	read1_zero: assert property (@(posedge clk) disable iff (!rst_n)
		decoded.rs1 == tiny_cpu_pkg::ZERO_REG |-> read_value1 == '0)
		else $error("read port 1 returned nonzero for the zero register");

	read2_zero: assert property (@(posedge clk) disable iff (!rst_n)
		decoded.rs2 == tiny_cpu_pkg::ZERO_REG |-> read_value2 == '0)
		else $error("read port 2 returned nonzero for the zero register");

endmodule

/* sim/tb_tiny_cpu.sv */
`timescale 1ns/100ps

module tb_tiny_cpu;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 4;
	localparam int N_RANDOM     = 200;
	localparam int N_CHAIN      = 40;
	localparam int DRAIN        = 5;
	// Worst case cycles, every random instruction followed by a gap
	localparam int MAX_CYCLES   = 2 * N_RANDOM + N_CHAIN + 2 + 7 + 8 + 5 + 5 * DRAIN;
	localparam int WATCHDOG_NS  = (MAX_CYCLES * 3 / 2 + RESET_CYCLES) * CLK_PERIOD;

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	logic [15:0]       instr;
	tiny_cpu_pkg::wb_t wb;
	logic [15:0]       debug_out;
	int                error_count;
	int                check_count;
	logic [31:0]       lfsr_state;
	int                issued;
	int                errs_before;

	tiny_cpu uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.debug_out   (debug_out)
	);

	cpu_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.debug_out   (debug_out),
		.error_count (error_count),
		.check_count (check_count)
	);

	bind tiny_cpu cpu_properties props (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb          (wb_q),
		.gen_write   (gen_write),
		.link_write  (link_write),
		.decoded     (decoded),
		.read_value1 (operand_a),
		.read_value2 (operand_b)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[31]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs1, input logic [3:0] rs2);
		return {op, rd, rs1, rs2};
	endfunction

	task automatic issue(input logic [15:0] word);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= word;
		issued++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr <= '0;
		end
	endtask

	task automatic finish_test(input string name);
		idle(DRAIN);
		// Counters settle after the edge
		@(negedge clk);
		$display("%s: %0d instructions, %0d errors", name, issued,
			error_count - errs_before);
		issued = 0;
		errs_before = error_count;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic run_random_alu;
		logic [15:0] v;
		logic [15:0] gap;
		for (int i = 0; i < N_RANDOM; i++) begin
			draw_bits(16, v);
			// Keep calls out, code 11 still decodes as a no-op
			if (v[15:12] == 4'd10)
				v[15:12] = 4'd11;
			issue(v);
			draw_bits(1, gap);
			if (gap[0])
				idle(1);
		end
	endtask

	task automatic run_forwarding;
		logic [15:0] v;
		logic [3:0]  prev1;
		logic [3:0]  prev2;
		logic [3:0]  rd;
		logic [3:0]  src;
		logic [3:0]  rs2;
		draw_bits(8, v);
		issue(encode(tiny_cpu_pkg::OP_LUI, 4'd1, v[7:4], v[3:0]));
		issue(encode(tiny_cpu_pkg::OP_ADDI, 4'd2, 4'd1, v[3:0]));
		prev1 = 4'd2;
		prev2 = 4'd1;
		for (int i = 0; i < N_CHAIN; i++) begin
			draw_bits(4, v);
			rd = (v[3:0] % 4'd12) + 4'd1;
			draw_bits(1, v);
			src = v[0] ? prev2 : prev1;
			draw_bits(4, v);
			rs2 = v[3] ? prev1 : v[3:0];
			draw_bits(3, v);
			issue(encode({1'b0, v[2:0]} + 4'd1, rd, src, rs2));
			prev2 = prev1;
			prev1 = rd;
		end
	endtask

	task automatic run_zero_reg;
		issue(encode(tiny_cpu_pkg::OP_LUI, 4'd3, 4'hA, 4'h5));
		issue(encode(tiny_cpu_pkg::OP_ADDI, 4'd3, 4'd3, 4'd3));
		issue(encode(tiny_cpu_pkg::OP_ADDI, 4'd0, 4'd3, 4'd7));
		issue(encode(tiny_cpu_pkg::OP_LUI, 4'd0, 4'h5, 4'h5));
		issue(encode(tiny_cpu_pkg::OP_ADD, 4'd6, 4'd0, 4'd3));
		issue(encode(tiny_cpu_pkg::OP_OR, 4'd7, 4'd0, 4'd0));
		issue(encode(tiny_cpu_pkg::OP_SUB, 4'd8, 4'd3, 4'd0));
	endtask

	task automatic run_link;
		issue(encode(tiny_cpu_pkg::OP_CALL, 4'd0, 4'd0, 4'd0));
		issue(encode(tiny_cpu_pkg::OP_ADD, 4'd8, 4'd13, 4'd0));
		issue(encode(tiny_cpu_pkg::OP_CALL, 4'd2, 4'd0, 4'd0));
		issue(encode(tiny_cpu_pkg::OP_NOP, 4'd0, 4'd0, 4'd0));
		issue(encode(tiny_cpu_pkg::OP_ADD, 4'd9, 4'd13, 4'd0));
		// General write to the link register is dropped
		issue(encode(tiny_cpu_pkg::OP_ADDI, 4'd13, 4'd1, 4'd9));
		issue(encode(tiny_cpu_pkg::OP_ADD, 4'd10, 4'd13, 4'd0));
		issue(encode(tiny_cpu_pkg::OP_SUB, 4'd11, 4'd13, 4'd8));
	endtask

	task automatic run_debug_word;
		logic [15:0] v;
		draw_bits(8, v);
		issue(encode(tiny_cpu_pkg::OP_LUI, 4'd4, v[7:4], v[3:0]));
		draw_bits(4, v);
		issue(encode(tiny_cpu_pkg::OP_ADDI, 4'd4, 4'd4, v[3:0]));
		draw_bits(8, v);
		issue(encode(tiny_cpu_pkg::OP_LUI, 4'd5, v[7:4], v[3:0]));
		draw_bits(4, v);
		issue(encode(tiny_cpu_pkg::OP_ADDI, 4'd5, 4'd5, v[3:0]));
		issue(encode(tiny_cpu_pkg::OP_NOP, 4'd0, 4'd0, 4'd0));
	endtask

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		lfsr_state = 32'h7266;
		issued = 0;
		errs_before = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		run_random_alu();
		finish_test("random alu");
		run_forwarding();
		finish_test("forwarding");
		run_zero_reg();
		finish_test("zero reg");
		run_link();
		finish_test("link reg");
		run_debug_word();
		finish_test("debug word");
		$display("Summary: %0d checks passed, %0d errors", check_count - error_count,
			error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
	input  tiny_cpu_pkg::exec_t               ex,
	output logic [tiny_cpu_pkg::DATA_W-1:0]   result,
	output logic [tiny_cpu_pkg::ADDR_W-1:0]   dest,
	output logic                              writes,
	output logic                              link
);

	logic [tiny_cpu_pkg::DATA_W-1:0] imm_ext;
	logic [3:0]                      shamt;

	assign imm_ext = {8'h00, ex.decoded.imm};
	assign shamt   = ex.b[3:0];

	always_comb begin
		case (ex.decoded.op)
			tiny_cpu_pkg::OP_ADD:  result = ex.a + ex.b;
			tiny_cpu_pkg::OP_SUB:  result = ex.a - ex.b;
			tiny_cpu_pkg::OP_AND:  result = ex.a & ex.b;
			tiny_cpu_pkg::OP_OR:   result = ex.a | ex.b;
			tiny_cpu_pkg::OP_XOR:  result = ex.a ^ ex.b;
			tiny_cpu_pkg::OP_SHL:  result = ex.a << shamt;
			tiny_cpu_pkg::OP_SHR:  result = ex.a >> shamt;
			tiny_cpu_pkg::OP_ADDI: result = ex.a + imm_ext;
			tiny_cpu_pkg::OP_LUI:  result = {ex.decoded.imm, 8'h00};
			tiny_cpu_pkg::OP_CALL: result = ex.link_value;
			default:               result = '0;
		endcase
	end

	// Calls always land in the link register
	assign dest = ex.decoded.is_call ? tiny_cpu_pkg::LINK_REG : ex.decoded.rd;

	assign writes = ex.valid &&
	                ((ex.decoded.rd_write && ex.decoded.rd != tiny_cpu_pkg::ZERO_REG) ||
	                 ex.decoded.is_call);

	assign link = ex.valid && ex.decoded.is_call;

endmodule

/* source/decoder.sv */
`timescale 1ns/100ps

module decoder (
	input  logic [tiny_cpu_pkg::INSTR_W-1:0] instr,
	output tiny_cpu_pkg::decoded_t           decoded
);

	logic [3:0] op_field;

	assign op_field = instr[15:12];

	always_comb begin
		decoded = '0;

		// Codes past OP_CALL are treated as no-ops
		if (op_field > 4'(tiny_cpu_pkg::OP_CALL))
			decoded.op = tiny_cpu_pkg::OP_NOP;
		else
			decoded.op = tiny_cpu_pkg::opcode_t'(op_field);

		decoded.rd  = instr[11:8];
		decoded.rs1 = instr[7:4];
		decoded.rs2 = instr[3:0];

		// LUI takes both source fields as one byte
		if (decoded.op == tiny_cpu_pkg::OP_LUI)
			decoded.imm = instr[7:0];
		else
			decoded.imm = {4'b0000, instr[3:0]};

		case (decoded.op)
			tiny_cpu_pkg::OP_ADD,
			tiny_cpu_pkg::OP_SUB,
			tiny_cpu_pkg::OP_AND,
			tiny_cpu_pkg::OP_OR,
			tiny_cpu_pkg::OP_XOR,
			tiny_cpu_pkg::OP_SHL,
			tiny_cpu_pkg::OP_SHR: begin
				decoded.read1    = 1'b1;
				decoded.read2    = 1'b1;
				decoded.rd_write = 1'b1;
			end
			tiny_cpu_pkg::OP_ADDI: begin
				decoded.read1    = 1'b1;
				decoded.rd_write = 1'b1;
			end
			tiny_cpu_pkg::OP_LUI: begin
				decoded.rd_write = 1'b1;
			end
			tiny_cpu_pkg::OP_CALL: begin
				decoded.is_call = 1'b1;
			end
			default: begin
				decoded.rd_write = 1'b0;
			end
		endcase

		// Link register is reserved for calls
		if (decoded.rd == tiny_cpu_pkg::LINK_REG)
			decoded.rd_write = 1'b0;
	end

endmodule

/* source/register.sv */
`timescale 1ns/100ps

module register #(
	parameter logic [tiny_cpu_pkg::ADDR_W-1:0] DEBUG_REG_A = 4'd4,
	parameter logic [tiny_cpu_pkg::ADDR_W-1:0] DEBUG_REG_B = 4'd5
) (
	input  logic clk,
	input  logic rst_n,

	input  logic                              writable,
	input  logic [tiny_cpu_pkg::ADDR_W-1:0]   write_addr,
	input  logic [tiny_cpu_pkg::DATA_W-1:0]   write_value,

	input  logic                              alu_writable,
	input  logic [tiny_cpu_pkg::ADDR_W-1:0]   alu_write_addr,
	input  logic [tiny_cpu_pkg::DATA_W-1:0]   alu_write_value,

	input  logic                              readable1,
	input  logic [tiny_cpu_pkg::ADDR_W-1:0]   read_addr1,
	output logic [tiny_cpu_pkg::DATA_W-1:0]   read_value1,

	input  logic                              readable2,
	input  logic [tiny_cpu_pkg::ADDR_W-1:0]   read_addr2,
	output logic [tiny_cpu_pkg::DATA_W-1:0]   read_value2,

	input  logic                              ra_writable,
	input  logic [tiny_cpu_pkg::DATA_W-1:0]   ra_value,

	output logic [15:0]                       debug_out
);

	// Register 0 has no storage
	logic [tiny_cpu_pkg::DATA_W-1:0] regs [1:15];

	logic [tiny_cpu_pkg::DATA_W-1:0] debug_a;
	logic [tiny_cpu_pkg::DATA_W-1:0] debug_b;

	// Stored value, zero register folded in
	function automatic logic [tiny_cpu_pkg::DATA_W-1:0] stored_value(
		input logic [tiny_cpu_pkg::ADDR_W-1:0] addr
	);
		if (addr == tiny_cpu_pkg::ZERO_REG)
			return '0;
		return regs[addr];
	endfunction

	// One read port: ALU result first, then writeback or link, then storage
	function automatic logic [tiny_cpu_pkg::DATA_W-1:0] read_port(
		input logic                            en,
		input logic [tiny_cpu_pkg::ADDR_W-1:0] addr
	);
		logic [tiny_cpu_pkg::DATA_W-1:0] value;
		if (!en || addr == tiny_cpu_pkg::ZERO_REG)
			value = '0;
		else if (alu_writable && alu_write_addr == addr)
			value = alu_write_value;
		else if (writable && write_addr == addr && addr != tiny_cpu_pkg::LINK_REG)
			value = write_value;
		else if (ra_writable && addr == tiny_cpu_pkg::LINK_REG)
			value = ra_value;
		else
			value = stored_value(addr);
		return value;
	endfunction

	always_comb begin
		read_value1 = read_port(readable1, read_addr1);
	end

	always_comb begin
		read_value2 = read_port(readable2, read_addr2);
	end

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 16; i++)
				regs[i] <= '0;
		end else begin
			// General port never touches the zero or link register
			if (writable && write_addr != tiny_cpu_pkg::ZERO_REG &&
			    write_addr != tiny_cpu_pkg::LINK_REG)
				regs[write_addr] <= write_value;
			if (ra_writable)
				regs[tiny_cpu_pkg::LINK_REG] <= ra_value;
		end
	end

	// Low bytes of the two watched registers
	always_comb begin
		debug_a = stored_value(DEBUG_REG_A);
		debug_b = stored_value(DEBUG_REG_B);
	end

	assign debug_out = {debug_a[7:0], debug_b[7:0]};

endmodule

/* source/tiny_cpu.sv */
`timescale 1ns/100ps

module tiny_cpu #(
	parameter logic [tiny_cpu_pkg::ADDR_W-1:0] DEBUG_REG_A = 4'd4,
	parameter logic [tiny_cpu_pkg::ADDR_W-1:0] DEBUG_REG_B = 4'd5
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              instr_valid,
	input  logic [tiny_cpu_pkg::INSTR_W-1:0]  instr,
	output tiny_cpu_pkg::wb_t                 wb,
	output logic [15:0]                       debug_out
);

	tiny_cpu_pkg::decoded_t          decoded;
	tiny_cpu_pkg::exec_t             ex_q;
	tiny_cpu_pkg::wb_t               wb_q;

	logic [tiny_cpu_pkg::DATA_W-1:0] operand_a;
	logic [tiny_cpu_pkg::DATA_W-1:0] operand_b;
	logic [tiny_cpu_pkg::DATA_W-1:0] instr_count;

	logic [tiny_cpu_pkg::DATA_W-1:0] alu_result;
	logic [tiny_cpu_pkg::ADDR_W-1:0] alu_dest;
	logic                            alu_writes;
	logic                            alu_link;

	logic                            gen_write;
	logic                            link_write;

	//////////////////////////////////////////////////////////////////////
	// Decode and operand read
	//////////////////////////////////////////////////////////////////////

	decoder u_decoder (
		.instr   (instr),
		.decoded (decoded)
	);

	register #(
		.DEBUG_REG_A (DEBUG_REG_A),
		.DEBUG_REG_B (DEBUG_REG_B)
	) u_register (
		.clk             (clk),
		.rst_n           (rst_n),
		.writable        (gen_write),
		.write_addr      (wb_q.addr),
		.write_value     (wb_q.value),
		.alu_writable    (alu_writes),
		.alu_write_addr  (alu_dest),
		.alu_write_value (alu_result),
		.readable1       (decoded.read1),
		.read_addr1      (decoded.rs1),
		.read_value1     (operand_a),
		.readable2       (decoded.read2),
		.read_addr2      (decoded.rs2),
		.read_value2     (operand_b),
		.ra_writable     (link_write),
		.ra_value        (wb_q.value),
		.debug_out       (debug_out)
	);

	// Accepted instruction count, feeds the call link value
	always_ff @(posedge clk) begin
		if (!rst_n)
			instr_count <= '0;
		else if (instr_valid)
			instr_count <= instr_count + 1'b1;
	end

	// Execute stage register
	always_ff @(posedge clk) begin
		ex_q.decoded    <= decoded;
		ex_q.a          <= operand_a;
		ex_q.b          <= operand_b;
		ex_q.link_value <= instr_count + 1'b1;
		if (!rst_n)
			ex_q.valid <= 1'b0;
		else
			ex_q.valid <= instr_valid;
	end

	//////////////////////////////////////////////////////////////////////
	// Execute and writeback
	//////////////////////////////////////////////////////////////////////

	alu u_alu (
		.ex     (ex_q),
		.result (alu_result),
		.dest   (alu_dest),
		.writes (alu_writes),
		.link   (alu_link)
	);

	// Non-writing slots carry zero address and value
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_q <= '0;
		end else begin
			wb_q.valid <= alu_writes;
			wb_q.link  <= alu_writes && alu_link;
			wb_q.addr  <= alu_writes ? alu_dest : tiny_cpu_pkg::ZERO_REG;
			wb_q.value <= alu_writes ? alu_result : '0;
		end
	end

	// Steer to the general port or the link port
	assign gen_write  = wb_q.valid && !wb_q.link;
	assign link_write = wb_q.valid && wb_q.link;

	assign wb = wb_q;

endmodule

/* source/tiny_cpu_pkg.sv */
package tiny_cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and special registers
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W  = 16;
	localparam int ADDR_W  = 4;
	localparam int INSTR_W = 16;

	// Reads as zero, writes dropped
	localparam logic [ADDR_W-1:0] ZERO_REG = 4'd0;
	// Written only through the link port
	localparam logic [ADDR_W-1:0] LINK_REG = 4'd13;

	//////////////////////////////////////////////////////////////////////
	// Opcodes, taken from instr[15:12]
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,
		OP_SHR  = 4'd7,
		OP_ADDI = 4'd8,
		OP_LUI  = 4'd9,
		OP_CALL = 4'd10
	} opcode_t;

	//////////////////////////////////////////////////////////////////////
	// Pipeline records
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_t           op;
		logic [ADDR_W-1:0] rd;
		logic [ADDR_W-1:0] rs1;
		logic [ADDR_W-1:0] rs2;
		logic [7:0]        imm;
		logic              rd_write;
		logic              is_call;
		logic              read1;
		logic              read2;
	} decoded_t;

	typedef struct packed {
		logic              valid;
		decoded_t          decoded;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] link_value;   // instruction count plus one
	} exec_t;

	typedef struct packed {
		logic              valid;
		logic              link;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] value;
	} wb_t;

endpackage

/* tiny_cpu.f */
source/tiny_cpu_pkg.sv
source/decoder.sv
source/alu.sv
source/register.sv
source/tiny_cpu.sv
sim/cpu_properties.sv
sim/cpu_checker.sv
sim/tb_tiny_cpu.sv
